// ==== verilog.f ====
design/ps2_pkg.sv
design/display_pkg.sv
design/ps2_receiver.sv
design/key_decoder.sv
design/seg7.sv
design/key_regs.sv
design/key_display_top.sv
tb/tb_clock.sv
tb/key_display_assert.sv
tb/key_display_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = key_display_tb
FILELIST = verilog.f
RUNARGS  = +verilator+error+limit+100

SOURCES  = $(shell cat $(FILELIST))
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNARGS)

clean:
	rm -rf obj_dir

// ==== tb/key_display_tb.sv ====
module key_display_tb
    import ps2_pkg::*;
();

    localparam int FIFO_DEPTH     = 8; // same as the DUT default.
    localparam int PS2_HALF       = 10;
    localparam int NUM_KEYS       = 8;
    localparam int DECODE_CYCLES  = 8;
    localparam int DRAIN_CYCLES   = 4 * FIFO_DEPTH + 8;
    // make alone, key sequences, bad parity, disabled sequence, overflow burst.
    localparam int NUM_FRAMES     = 1 + 3 * NUM_KEYS + 1 + 3 + FIFO_DEPTH + 2;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_BITS * 2 * PS2_HALF + 2000;

    logic        clk;
    logic        rst;
    logic        ps2_clk;
    logic        ps2_dat;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [7:0]  seg1;
    logic [7:0]  seg2;

    logic [15:0] lfsr;
    logic [2:0]  exp_ctrl;
    logic [7:0]  exp_key;
    logic [7:0]  exp_count;
    logic [1:0]  exp_status;
    logic [7:0]  burst [$];

    tb_clock u_clock (.clk(clk), .rst(rst));

    key_display_top UUT (
        .clk(clk),
        .rst(rst),
        .ps2_clk(ps2_clk),
        .ps2_dat(ps2_dat),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .seg1(seg1),
        .seg2(seg2)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic is_mapped(input logic [3:0] addr);
        return (addr == REG_CTRL) || (addr == REG_KEY) || (addr == REG_STATUS);
    endfunction

    function automatic logic [31:0] expected_reg(input logic [3:0] addr);
        case (addr)
            REG_CTRL:   return {29'd0, exp_ctrl};
            REG_KEY:    return {16'd0, exp_count, exp_key};
            REG_STATUS: return {30'd0, exp_status};
            default:    return 32'd0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal;
        end
    endtask

    task automatic draw_code(output logic [7:0] code);
        int i;
        code = BREAK_CODE;
        while (code == BREAK_CODE) // the prefix is never used as a key.
        begin
            for (i = 0; i < 8; i++)
            begin
                lfsr    = lfsr_next(lfsr);
                code[i] = lfsr[0];
            end
        end
    endtask

    // start, data LSB first, odd parity, stop; data changes while ps2_clk is high.
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [FRAME_BITS-1:0] bits;
        int i;
        bits = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
        @(negedge clk);
        for (i = 0; i < FRAME_BITS; i++)
        begin
            ps2_dat = bits[i];
            repeat (PS2_HALF) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
    endtask

    task automatic send_key(input logic [7:0] code);
        send_frame(code, 1'b0);
        send_frame(BREAK_CODE, 1'b0);
        send_frame(code, 1'b0);
        repeat (DECODE_CYCLES) @(negedge clk);
    endtask

    task automatic key_released(input logic [7:0] code);
        exp_key              = code;
        exp_count            = exp_count + 8'd1;
        exp_ctrl[CTRL_BLANK] = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             input string name);
        logic err;
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        compare({name, " pslverr"}, {31'd0, !is_mapped(addr)}, {31'd0, err});
    endtask

    task automatic apb_read(input logic [3:0] addr, input string name);
        logic [31:0] data;
        logic        err;
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        data    = prdata; // held since the access edge.
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
        compare({name, " pslverr"}, {31'd0, !is_mapped(addr)}, {31'd0, err});
        if (is_mapped(addr))
            compare(name, expected_reg(addr), data);
    endtask

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("simulation timed out");
        $display("*** TEST FAILED ***");
        $fatal;
    end

    always @(negedge clk)
    begin
        if (UUT.u_check.fail_count != 0)
        begin
            $display("a bound assertion on the DUT failed");
            $display("*** TEST FAILED ***");
            $fatal;
        end
    end

    initial
    begin
        int i;
        logic [7:0] code;
        logic waiting;
        ps2_clk    = 1'b1;
        ps2_dat    = 1'b1;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        lfsr       = 16'd53;
        exp_ctrl   = 3'b101;
        exp_key    = '0;
        exp_count  = '0;
        exp_status = '0;
        wait (rst == 1'b1);
        @(negedge clk);

        apb_read(REG_CTRL, "reset ctrl");
        apb_read(REG_KEY, "reset key");
        apb_read(REG_STATUS, "reset status");

        draw_code(code);
        send_frame(code, 1'b0); // make alone.
        repeat (DECODE_CYCLES) @(negedge clk);
        apb_read(REG_KEY, "make only");
        for (i = 0; i < NUM_KEYS; i++)
        begin
            draw_code(code);
            send_key(code);
            key_released(code);
            apb_read(REG_KEY, "released key");
            apb_read(REG_CTRL, "blank after key");
        end

        draw_code(code);
        send_frame(code, 1'b1);
        repeat (DECODE_CYCLES) @(negedge clk);
        exp_status[STAT_PARITY] = 1'b1;
        apb_read(REG_STATUS, "parity flag");
        apb_read(REG_KEY, "parity key");
        apb_write(REG_STATUS, 32'h1, "parity clear");
        exp_status[STAT_PARITY] = 1'b0;
        apb_read(REG_STATUS, "parity cleared");

        apb_write(REG_CTRL, 32'h0, "disable");
        exp_ctrl = 3'b000;
        draw_code(code);
        send_key(code);
        apb_read(REG_KEY, "disabled key");
        apb_write(REG_CTRL, 32'h5, "blank on");
        exp_ctrl = 3'b101;
        apb_read(REG_CTRL, "blank ctrl");
        apb_read(REG_KEY, "blank key");
        apb_write(REG_CTRL, 32'h1, "blank off");
        exp_ctrl = 3'b001;

        apb_write(REG_CTRL, 32'h3, "pause on");
        exp_ctrl = 3'b011;
        for (i = 0; i < FIFO_DEPTH + 2; i++)
        begin
            if (i % 2 == 0)
                code = BREAK_CODE;
            else
                draw_code(code);
            send_frame(code, 1'b0);
            if (i < FIFO_DEPTH)
                burst.push_back(code); // later frames find the FIFO full.
        end
        exp_status[STAT_OVERFLOW] = 1'b1;
        apb_read(REG_STATUS, "overflow flag");
        apb_read(REG_KEY, "paused key");
        apb_write(REG_CTRL, 32'h1, "pause off");
        exp_ctrl = 3'b001;
        repeat (DRAIN_CYCLES) @(negedge clk);
        waiting = 1'b0;
        foreach (burst[j])
        begin
            if (burst[j] == BREAK_CODE)
                waiting = 1'b1;
            else if (waiting)
            begin
                key_released(burst[j]);
                waiting = 1'b0;
            end
        end
        apb_read(REG_KEY, "drained key");
        apb_write(REG_STATUS, 32'h2, "overflow clear");
        exp_status[STAT_OVERFLOW] = 1'b0;
        apb_read(REG_STATUS, "overflow cleared");

        apb_read(4'hC, "unmapped read");
        apb_write(4'hC, 32'hFFFF_FFFF, "unmapped write");
        apb_read(REG_CTRL, "after unmapped ctrl");
        apb_read(REG_KEY, "after unmapped key");
        apb_read(REG_STATUS, "after unmapped status");

        @(negedge clk);
        if (UUT.u_check.fail_count == 0)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
        begin
            $display("*** TEST FAILED ***");
            $fatal;
        end
    end

endmodule

// ==== tb/key_display_assert.sv ====
module key_display_assert
    import ps2_pkg::*, display_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic [3:0] paddr,
    input logic       psel,
    input logic       penable,
    input logic       pready,
    input logic       pslverr,
    input logic       blank,
    input logic [7:0] last_key,
    input seg_t       seg1,
    input seg_t       seg2
);

    // active-low g..a per hex digit, decimal point off.
    localparam seg_t DIGITS [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
    };

    int unsigned fail_count = 0;
    logic        unmapped;

    assign unmapped = (paddr != REG_CTRL) && (paddr != REG_KEY) && (paddr != REG_STATUS);

    // an access cycle is the one right after a setup cycle.
    a_pready: assert property (@(posedge clk) disable iff (!rst)
        pready == (psel && penable && $past(psel && !penable)))
    else
    begin
        $error("pready does not match the access phase");
        fail_count++;
    end

    a_pslverr: assert property (@(posedge clk) disable iff (!rst)
        pslverr |-> (pready && unmapped))
    else
    begin
        $error("pslverr does not match the address decode");
        fail_count++;
    end

    a_blank: assert property (@(posedge clk) disable iff (!rst)
        blank |-> (seg1 == SEG_BLANK && seg2 == SEG_BLANK))
    else
    begin
        $error("display lit while blank is set");
        fail_count++;
    end

    a_digits: assert property (@(posedge clk) disable iff (!rst)
        !blank |-> (seg1 == DIGITS[last_key[3:0]] && seg2 == DIGITS[last_key[7:4]]))
    else
    begin
        $error("segments do not show the last key");
        fail_count++;
    end

endmodule

bind key_display_top key_display_assert u_check (
    .clk(clk),
    .rst(rst),
    .paddr(paddr),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr),
    .blank(blank),
    .last_key(last_key),
    .seg1(seg1),
    .seg2(seg2)
);

// ==== tb/tb_clock.sv ====
module tb_clock
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1; // released away from the active edge.
    end

    always #50 clk = ~clk;

endmodule

// ==== design/key_display_top.sv ====
module key_display_top
#(
    parameter int FIFO_DEPTH    = 8,
    parameter int BREAK_TIMEOUT = 4096
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        ps2_clk,
    input  logic        ps2_dat,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [7:0]  seg1,
    output logic [7:0]  seg2
);

    logic       rx_enable;
    logic       rx_ready;
    logic [7:0] rx_data;
    logic       rx_pop;
    logic       flush;
    logic       parity_pulse;
    logic       overflow_pulse;
    logic       pause;
    logic       key_valid;
    logic [7:0] key_code;
    logic [7:0] last_key;
    logic       blank;

    ps2_receiver #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_receiver (
        .clk(clk),
        .rst(rst),
        .rx_enable(rx_enable),
        .ps2_clk(ps2_clk),
        .ps2_dat(ps2_dat),
        .rx_pop(rx_pop),
        .flush(flush),
        .rx_ready(rx_ready),
        .rx_data(rx_data),
        .parity_pulse(parity_pulse),
        .overflow_pulse(overflow_pulse)
    );

    key_decoder #(
        .BREAK_TIMEOUT(BREAK_TIMEOUT)
    ) u_decoder (
        .clk(clk),
        .rst(rst),
        .rx_ready(rx_ready),
        .rx_data(rx_data),
        .pause(pause),
        .rx_pop(rx_pop),
        .flush(flush),
        .key_valid(key_valid),
        .key_code(key_code)
    );

    key_regs u_regs (
        .clk(clk),
        .rst(rst),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .key_valid(key_valid),
        .key_code(key_code),
        .parity_pulse(parity_pulse),
        .overflow_pulse(overflow_pulse),
        .rx_enable(rx_enable),
        .pause(pause),
        .blank(blank),
        .last_key(last_key)
    );

    seg7 u_seg_lo (
        .num(last_key[3:0]),
        .blank(blank),
        .seg_out(seg1)
    );

    seg7 u_seg_hi (
        .num(last_key[7:4]),
        .blank(blank),
        .seg_out(seg2)
    );

endmodule

// ==== design/key_regs.sv ====
module key_regs
    import ps2_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        key_valid,
    input  ps2_byte_t   key_code,
    input  logic        parity_pulse,
    input  logic        overflow_pulse,
    output logic        rx_enable,
    output logic        pause,
    output logic        blank,
    output ps2_byte_t   last_key
);

    logic       access;
    logic       mapped;
    logic       wr_en;
    logic [7:0] key_count;
    logic       stat_parity;
    logic       stat_overflow;

    assign access  = psel && penable;
    assign mapped  = (paddr == REG_CTRL) || (paddr == REG_KEY) || (paddr == REG_STATUS);
    assign wr_en   = access && pwrite && mapped;
    assign pready  = access; // no wait states.
    assign pslverr = access && !mapped;

    always_comb
    begin
        prdata = '0;
        case (paddr)
            REG_CTRL:
            begin
                prdata[CTRL_ENABLE] = rx_enable;
                prdata[CTRL_PAUSE]  = pause;
                prdata[CTRL_BLANK]  = blank;
            end
            REG_KEY:
                prdata[15:0] = {key_count, last_key};
            REG_STATUS:
            begin
                prdata[STAT_PARITY]   = stat_parity;
                prdata[STAT_OVERFLOW] = stat_overflow;
            end
            default:
                prdata = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            rx_enable     <= 1'b1;
            pause         <= 1'b0;
            blank         <= 1'b1;
            last_key      <= '0;
            key_count     <= '0;
            stat_parity   <= 1'b0;
            stat_overflow <= 1'b0;
        end
        else
        begin
            if (wr_en && paddr == REG_CTRL)
            begin
                rx_enable <= pwdata[CTRL_ENABLE];
                pause     <= pwdata[CTRL_PAUSE];
                blank     <= pwdata[CTRL_BLANK];
            end
            if (wr_en && paddr == REG_STATUS)
            begin
                if (pwdata[STAT_PARITY])
                    stat_parity <= 1'b0;
                if (pwdata[STAT_OVERFLOW])
                    stat_overflow <= 1'b0;
            end
            if (key_valid)
            begin
                last_key  <= key_code;
                key_count <= key_count + 1'b1; // wraps at 256.
                blank     <= 1'b0;
            end
            // a new event wins over a clear in the same cycle.
            if (parity_pulse)
                stat_parity <= 1'b1;
            if (overflow_pulse)
                stat_overflow <= 1'b1;
        end
    end

endmodule

// ==== design/seg7.sv ====
module seg7
    import display_pkg::*;
(
    input  nibble_t num,
    input  logic    blank,
    output seg_t    seg_out
);

    always_comb
    begin
        case (num)
            4'h0:    seg_out = 8'hC0;
            4'h1:    seg_out = 8'hF9;
            4'h2:    seg_out = 8'hA4;
            4'h3:    seg_out = 8'hB0;
            4'h4:    seg_out = 8'h99;
            4'h5:    seg_out = 8'h92;
            4'h6:    seg_out = 8'h82;
            4'h7:    seg_out = 8'hF8;
            4'h8:    seg_out = 8'h80;
            4'h9:    seg_out = 8'h90;
            4'hA:    seg_out = 8'h88;
            4'hB:    seg_out = 8'h83; // lower case b.
            4'hC:    seg_out = 8'hC6;
            4'hD:    seg_out = 8'hA1; // lower case d.
            4'hE:    seg_out = 8'h86;
            default: seg_out = 8'h8E;
        endcase
        if (blank)
            seg_out = SEG_BLANK;
    end

endmodule

// ==== design/key_decoder.sv ====
module key_decoder
    import ps2_pkg::*;
#(
    parameter int BREAK_TIMEOUT = 4096
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rx_ready,
    input  ps2_byte_t rx_data,
    input  logic      pause,
    output logic      rx_pop,
    output logic      flush,
    output logic      key_valid,
    output ps2_byte_t key_code
);

    localparam int TW = (BREAK_TIMEOUT > 1) ? $clog2(BREAK_TIMEOUT) : 1;
    localparam logic [TW-1:0] TIMEOUT_LAST = TW'(BREAK_TIMEOUT - 1);

    typedef enum logic [2:0] {
        IDLE,
        POP,
        CHECK,
        WAIT_KEY,
        POP_KEY,
        REPORT
    } state_t;

    state_t    state;
    ps2_byte_t byte_q;
    logic [TW-1:0] timer;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state <= IDLE;
            timer <= '0;
            flush <= 1'b0;
        end
        else
        begin
            flush <= 1'b0;
            case (state)
                IDLE:
                    if (rx_ready && !pause && !flush) // head is stale while flushing.
                        state <= POP;
                POP:
                    state <= CHECK;
                CHECK:
                begin
                    timer <= '0;
                    state <= (byte_q == BREAK_CODE) ? WAIT_KEY : IDLE; // make codes dropped.
                end
                WAIT_KEY:
                begin
                    if (rx_ready && !pause)
                        state <= POP_KEY;
                    else if (timer == TIMEOUT_LAST)
                    begin
                        flush <= 1'b1; // key byte never came.
                        state <= IDLE;
                    end
                    else if (!pause)
                        timer <= timer + 1'b1;
                end
                POP_KEY:
                    state <= REPORT;
                REPORT:
                    state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == POP)
            byte_q <= rx_data;
        if (state == POP_KEY)
            key_code <= rx_data;
    end

    assign rx_pop    = (state == POP) || (state == POP_KEY);
    assign key_valid = (state == REPORT);

endmodule

// ==== design/ps2_receiver.sv ====
module ps2_receiver
    import ps2_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rx_enable,
    input  logic      ps2_clk,
    input  logic      ps2_dat,
    input  logic      rx_pop,
    input  logic      flush,
    output logic      rx_ready,
    output ps2_byte_t rx_data,
    output logic      parity_pulse,
    output logic      overflow_pulse
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int BIT_W = $clog2(FRAME_BITS + 1);

    logic [2:0]            clk_sync;
    logic [1:0]            dat_sync;
    logic                  fall;
    logic [FRAME_BITS-1:0] frame;
    logic [BIT_W-1:0]      bit_cnt;
    logic                  frame_done;
    logic                  frame_ok;
    logic                  parity_ok;
    logic                  good;
    ps2_byte_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  full;
    logic                  push;
    logic                  pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // two synchronizer stages, the third one only for edge detection.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= 3'b111;
            dat_sync <= 2'b11;
        end
        else
        begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
        end
    end

    assign fall = clk_sync[2] & ~clk_sync[1];

    always_ff @(posedge clk)
    begin
        if (!rst || !rx_enable)
        begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (fall)
            begin
                if (bit_cnt == BIT_W'(FRAME_BITS - 1))
                begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;
                end
                else if (bit_cnt != '0 || !dat_sync[1]) // wait for a low start bit.
                    bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall)
            frame <= {dat_sync[1], frame[FRAME_BITS-1:1]}; // LSB arrives first.
    end

    assign frame_ok  = !frame[0] && frame[FRAME_BITS-1];
    assign parity_ok = ^frame[FRAME_BITS-2:1]; // odd over data and parity.
    assign good      = frame_done && frame_ok && parity_ok;

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign push     = good && !full;
    assign pop      = rx_pop && (count != '0);
    assign rx_ready = (count != '0);
    assign rx_data  = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            parity_pulse   <= 1'b0;
            overflow_pulse <= 1'b0;
        end
        else
        begin
            parity_pulse   <= frame_done && frame_ok && !parity_ok;
            overflow_pulse <= good && full; // byte is dropped.
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst || flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= frame[8:1];
    end

endmodule

// ==== design/display_pkg.sv ====
package display_pkg;

    // active-low segments, bit 7 is the decimal point and bits 6:0 are g..a.
    typedef logic [7:0] seg_t;

    // one hex digit.
    typedef logic [3:0] nibble_t;

    localparam seg_t SEG_BLANK = 8'hFF; // every segment off.

endpackage

// ==== design/ps2_pkg.sv ====
package ps2_pkg;

    // one scan-code byte as it leaves the receiver.
    typedef logic [7:0] ps2_byte_t;

    localparam ps2_byte_t BREAK_CODE = 8'hF0; // prefix sent before a released key.

    // start, 8 data bits LSB first, odd parity, stop.
    localparam int FRAME_BITS = 11;

    // APB register map, byte offsets.
    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_KEY    = 4'h4;
    localparam logic [3:0] REG_STATUS = 4'h8;

    // control register bits.
    localparam int CTRL_ENABLE = 0;
    localparam int CTRL_PAUSE  = 1;
    localparam int CTRL_BLANK  = 2;

    // sticky status bits, write one to clear.
    localparam int STAT_PARITY   = 0;
    localparam int STAT_OVERFLOW = 1;

endpackage
